// File: list.f
+incdir+source
source/csr_pkg.sv
source/clic_pkg.sv
source/csr_reg.sv
source/epc_stack.sv
source/clic_timer.sv
source/n_clic.sv
sim/tb_clk_gen.sv
sim/n_clic_assert.sv
sim/n_clic_tb.sv

// File: sim/n_clic_assert.sv
// concurrent checks on return stack control and tail chaining that get bound into the controller
`timescale 1ns/1ps
`include "clic_cfg.svh"

module n_clic_assert (
  input logic             clk,
  input logic             reset,
  input logic             push_i,
  input logic             pop_i,
  input clic_pkg::level_t level_i,
  input logic             tail_chain_i
);
  import clic_pkg::*;

  // count of failed checks
  int fail_count;

  initial begin
    fail_count = 0;
  end

  // an accepted push or pop moves the level by exactly one
  push_adds_level: assert property (
    @(posedge clk) disable iff (reset)
      (push_i && level_i < level_t'(`CLIC_STACK_DEPTH)) |=>
      (level_i == $past(level_i) + 1'b1)
  ) else begin
    $error("stack level did not grow after a push");
    fail_count++;
  end

  // a push in the same cycle would win and break this one
  pop_drops_level: assert property (
    @(posedge clk) disable iff (reset)
      (pop_i && level_i != '0) |=> (level_i == $past(level_i) - 1'b1)
  ) else begin
    $error("stack level did not shrink after a pop");
    fail_count++;
  end

  level_in_range: assert property (
    @(posedge clk) disable iff (reset) level_i <= level_t'(`CLIC_STACK_DEPTH)
  ) else begin
    $error("stack level beyond the configured depth");
    fail_count++;
  end

  // a tail chain neither pushes nor pops
  tail_keeps_level: assert property (
    @(posedge clk) disable iff (reset) tail_chain_i |=> (level_i == $past(level_i))
  ) else begin
    $error("stack level changed across a tail chain");
    fail_count++;
  end

endmodule

// File: sim/n_clic_tb.sv
// testbench top for the interrupt controller that replays the trace file and checks every cycle
`timescale 1ns/1ps
`include "clic_cfg.svh"

module n_clic_tb;
  import csr_pkg::*;
  import clic_pkg::*;

  localparam int NUM_COLS     = 14;
  localparam int MAX_RECS     = 256;
  localparam int RESET_CYCLES = 5;
  localparam int SLACK_CYCLES = 20;

  // trace columns with inputs first then expected outputs
  localparam int COL_EN   = 0;
  localparam int COL_OP   = 1;
  localparam int COL_ADDR = 2;
  localparam int COL_DATA = 3;
  localparam int COL_ZIMM = 4;
  localparam int COL_PC   = 5;
  localparam int COL_IRQ  = 6;
  localparam int COL_INT  = 7;
  localparam int COL_TAIL = 8;
  localparam int COL_IADR = 9;
  localparam int COL_ID   = 10;
  localparam int COL_LVL  = 11;
  localparam int COL_CSR  = 12;
  localparam int COL_IGN  = 13;

  logic       clk;
  logic       reset;
  logic       csr_enable;
  csr_addr_t  csr_addr;
  csr_op_t    csr_op;
  word_t      rs1_data;
  zimm_t      rs1_zimm;
  imem_addr_t pc;
  logic       interrupt_in;
  word_t      csr_out;
  imem_addr_t int_addr;
  vec_id_t    int_id;
  prio_t      int_prio;
  pc_sel_t    pc_sel;
  level_t     level;
  logic       interrupt;
  logic       tail_chain;

  logic [31:0] trace_mem [MAX_RECS*NUM_COLS];
  int          num_recs;
  int          cycle_limit;
  int          cycle_cnt;

  tb_clk_gen u_clk_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  n_clic dut (
    .clk,
    .reset,
    .csr_enable_i       (csr_enable),
    .csr_addr_i         (csr_addr),
    .csr_op_i           (csr_op),
    .rs1_data_i         (rs1_data),
    .rs1_zimm_i         (rs1_zimm),
    .pc_i               (pc),
    .interrupt_in_i     (interrupt_in),
    .csr_out_o          (csr_out),
    .int_addr_o         (int_addr),
    .int_id_o           (int_id),
    .int_prio_o         (int_prio),
    .pc_interrupt_sel_o (pc_sel),
    .level_o            (level),
    .interrupt_o        (interrupt),
    .tail_chain_o       (tail_chain)
  );

  bind n_clic n_clic_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .push_i       (push),
    .pop_i        (pop),
    .level_i      (level_o),
    .tail_chain_i (tail_chain_o)
  );

  function automatic logic [31:0] trace_word(input int r, input int c);
    return trace_mem[r*NUM_COLS + c];
  endfunction

  // records end at the first unwritten slot
  function automatic int count_records();
    int n;
    n = 0;
    while (n < MAX_RECS && !$isunknown(trace_mem[n*NUM_COLS])) begin
      n++;
    end
    return n;
  endfunction

  task automatic apply_inputs(input int r);
    logic [31:0] op_word;
    op_word = trace_word(r, COL_OP);
    csr_enable   <= (trace_word(r, COL_EN) != 0);
    csr_op       <= csr_op_t'(op_word[2:0]);
    csr_addr     <= csr_addr_t'(trace_word(r, COL_ADDR));
    rs1_data     <= trace_word(r, COL_DATA);
    rs1_zimm     <= zimm_t'(trace_word(r, COL_ZIMM));
    pc           <= imem_addr_t'(trace_word(r, COL_PC));
    interrupt_in <= (trace_word(r, COL_IRQ) != 0);
  endtask

  task automatic check_value(input string name, input int r,
                             input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s in record %0d: got %h, expected %h", name, r, got, exp);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // int_prio_o is the threshold the next record reads back
  // unless software writes the threshold in this cycle
  task automatic check_prio(input int r);
    logic next_reads_thresh;
    logic thresh_written;
    next_reads_thresh = (r + 1 < num_recs) &&
                        (trace_word(r + 1, COL_ADDR) == 32'(`CLIC_THRESH_ADDR)) &&
                        (trace_word(r + 1, COL_IGN) == 0);
    thresh_written = (trace_word(r, COL_EN) != 0) &&
                     (trace_word(r, COL_ADDR) == 32'(`CLIC_THRESH_ADDR));
    if (next_reads_thresh && !thresh_written) begin
      check_value("int_prio_o", r, 32'(int_prio), trace_word(r + 1, COL_CSR));
    end
  endtask

  task automatic check_outputs(input int r);
    logic redirect;
    // a take, a tail chain or a return sends the core away from pc_i
    redirect = (trace_word(r, COL_INT) != 0) ||
               (trace_word(r, COL_IADR) != trace_word(r, COL_PC));
    check_value("interrupt_o", r, 32'(interrupt), trace_word(r, COL_INT));
    check_value("tail_chain_o", r, 32'(tail_chain), trace_word(r, COL_TAIL));
    check_value("int_addr_o", r, 32'(int_addr), trace_word(r, COL_IADR));
    check_value("int_id_o", r, 32'(int_id), trace_word(r, COL_ID));
    check_value("level_o", r, 32'(level), trace_word(r, COL_LVL));
    check_value("pc_interrupt_sel_o", r, 32'(pc_sel),
                redirect ? 32'(PC_INTERRUPT) : 32'(PC_NORMAL));
    if (trace_word(r, COL_IGN) == 0) begin
      check_value("csr_out_o", r, csr_out, trace_word(r, COL_CSR));
    end
    check_prio(r);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the trace did not finish", cycle_cnt);
      $display("Something failed");
      $fatal(1);
    end
  end

  initial begin
    csr_enable   = 1'b0;
    csr_op       = CSR_RW;
    csr_addr     = '0;
    rs1_data     = '0;
    rs1_zimm     = '0;
    pc           = '0;
    interrupt_in = 1'b0;
    cycle_cnt    = 0;
    cycle_limit  = 0;
    $readmemh("sim/n_clic_trace.txt", trace_mem);
    num_recs = count_records();
    assert (num_recs > 0) else begin
      $display("no records could be read from the trace file");
      $display("Something failed");
      $fatal(1);
    end
    cycle_limit = num_recs + RESET_CYCLES + SLACK_CYCLES;
    @(negedge reset);
    for (int r = 0; r < num_recs; r++) begin
      @(posedge clk);
      apply_inputs(r);
      @(negedge clk);
      check_outputs(r);
    end
    if (dut.u_assert.fail_count == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("%0d bound assertion failures", dut.u_assert.fail_count);
      $display("Something failed");
      $fatal(1);
    end
  end

endmodule

// File: sim/n_clic_trace.txt
// inputs: en op addr wdata zimm pc irq_in
// expected: interrupt tail int_addr int_id level csr_out ignore_csr
// csr ops on the threshold
1 1 347 00000005 00 0100 0   0 0 0100 0 0 00000000 0
1 2 347 00000002 00 0100 0   0 0 0100 0 0 00000005 0
1 3 347 00000004 00 0100 0   0 0 0100 0 0 00000007 0
1 5 347 00000000 06 0100 0   0 0 0100 0 0 00000003 0
1 6 347 00000000 01 0100 0   0 0 0100 0 0 00000006 0
1 7 347 00000000 07 0100 0   0 0 0100 0 0 00000007 0
0 1 347 00000000 00 0100 0   0 0 0100 0 0 00000000 0
// csr ops on vector 3
1 1 b03 00000123 00 0100 0   0 0 0100 0 0 00000000 0
1 2 b03 00003000 00 0100 0   0 0 0100 0 0 00000123 0
1 3 b03 00003000 00 0100 0   0 0 0100 0 0 00003123 0
1 6 b03 00000000 10 0100 0   0 0 0100 0 0 00000123 0
1 7 b03 00000000 10 0100 0   0 0 0100 0 0 00000133 0
0 1 b03 00000000 00 0100 0   0 0 0100 0 0 00000123 0
// take of entry 3
1 1 b23 0000000b 00 0100 0   0 0 0100 0 0 00000000 0
1 6 300 00000000 08 0100 0   0 0 0100 0 0 00000000 0
0 1 b23 00000000 00 0120 0   1 0 048c 3 0 0000000b 0
0 1 b23 00000000 00 0100 0   0 0 0100 3 1 0000000a 0
0 1 347 00000000 00 0100 0   0 0 0100 3 1 00000002 0
// entry 5 preempts, then return
1 1 b05 00000200 00 0100 0   0 0 0100 3 1 00000000 0
1 1 b25 00000017 00 0100 0   0 0 0100 3 1 00000000 0
0 1 347 00000000 00 0110 0   1 0 0800 5 1 00000002 0
0 1 350 00000000 00 0100 0   0 0 0100 5 2 00000002 0
0 1 347 00000000 00 ffff 0   0 0 0110 3 2 00000005 0
0 1 347 00000000 00 0100 0   0 0 0100 3 1 00000002 0
// equal priority entry 2 tail chains at return
1 1 b02 00000050 00 0100 0   0 0 0100 3 1 00000000 0
1 1 b22 0000000b 00 0100 0   0 0 0100 3 1 00000000 0
0 1 b22 00000000 00 0100 0   0 0 0100 3 1 0000000b 0
0 1 347 00000000 00 ffff 0   1 1 0140 2 1 00000002 0
0 1 b22 00000000 00 0100 0   0 0 0100 2 1 0000000a 0
0 1 347 00000000 00 ffff 0   0 0 0120 0 1 00000002 0
0 1 347 00000000 00 0100 0   0 0 0100 0 0 00000000 0
// timer pends entry 0 with interrupts off, no take
1 7 300 00000000 08 0100 0   0 0 0100 0 0 00000008 0
1 1 b00 000000a0 00 0100 0   0 0 0100 0 0 00000000 0
1 1 b20 00000006 00 0100 0   0 0 0100 0 0 00000000 0
1 1 401 00000003 00 0100 0   0 0 0100 0 0 00000000 0
1 1 400 00000000 00 0100 0   0 0 0100 0 0 00000000 1
0 1 400 00000000 00 0100 0   0 0 0100 0 0 00000000 0
0 1 400 00000000 00 0100 0   0 0 0100 0 0 00000001 0
0 1 400 00000000 00 0100 0   0 0 0100 0 0 00000002 0
0 1 400 00000000 00 0100 0   0 0 0100 0 0 00000003 0
0 1 400 00000000 00 0100 0   0 0 0100 0 0 00000000 0
0 1 b20 00000000 00 0100 0   0 0 0100 0 0 00000007 0
1 1 401 00000000 00 0100 0   0 0 0100 0 0 00000003 0
// interrupts on, entry 0 taken
1 6 300 00000000 08 0100 0   0 0 0100 0 0 00000000 0
0 1 b20 00000000 00 0100 0   1 0 0280 0 0 00000007 0
0 1 b20 00000000 00 0100 0   0 0 0100 0 1 00000006 0
// fault line preempts with id 7, then two returns
1 1 b07 000003ff 00 0100 0   0 0 0100 0 1 00000000 0
0 1 347 00000000 00 0130 1   1 0 0ffc 7 1 00000001 0
0 1 347 00000000 00 0100 0   0 0 0100 7 2 00000007 0
0 1 347 00000000 00 ffff 0   0 0 0130 0 2 00000007 0
0 1 347 00000000 00 ffff 0   0 0 0100 0 1 00000001 0
0 1 350 00000000 00 0100 0   0 0 0100 0 0 00000000 0

// File: sim/tb_clk_gen.sv
// testbench clock and reset source, 8 ns clock with reset held for the first five edges
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: source/clic_cfg.svh
// interrupt controller sizes and CSR map, included by the packages and RTL that need them
`ifndef CLIC_CFG_SVH
`define CLIC_CFG_SVH

// the last source is the fault line
`define CLIC_VEC_SIZE 8
`define CLIC_PRIO_WIDTH 3
`define CLIC_IMEM_ADDR_WIDTH 16
`define CLIC_STACK_DEPTH 8

// fixed CSR addresses
`define CLIC_MSTATUS_ADDR 12'h300
`define CLIC_THRESH_ADDR 12'h347
`define CLIC_DEPTH_ADDR 12'h350
`define CLIC_TIMER_CNT_ADDR 12'h400
`define CLIC_TIMER_CMP_ADDR 12'h401

// one register per source, indexed from these
`define CLIC_VEC_BASE 12'hb00
`define CLIC_ENTRY_BASE 12'hb20

`endif

// File: source/clic_pkg.sv
// interrupt controller types, imported by the stack and the controller top level
`include "clic_cfg.svh"

package clic_pkg;

  typedef logic [`CLIC_PRIO_WIDTH-1:0] prio_t;

  typedef logic [3:0] vec_id_t;

  // byte address into instruction memory
  typedef logic [`CLIC_IMEM_ADDR_WIDTH-1:0] imem_addr_t;

  // number of saved contexts, 0 up to the full depth
  typedef logic [$clog2(`CLIC_STACK_DEPTH + 1)-1:0] level_t;

  typedef enum logic {
    PC_NORMAL,
    PC_INTERRUPT
  } pc_sel_t;

  typedef enum logic [1:0] {
    ACT_NONE,
    ACT_TAKE,
    ACT_TAIL,
    ACT_RETURN
  } clic_action_t;

endpackage

// File: source/clic_timer.sv
// compare timer, free counter plus compare CSR, pulses irq_o when they meet
`timescale 1ns/1ps
`include "clic_cfg.svh"

module clic_timer (
  input  logic               clk,
  input  logic               reset,
  input  logic               csr_enable_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_op_t   csr_op_i,
  input  csr_pkg::word_t     rs1_data_i,
  input  csr_pkg::zimm_t     rs1_zimm_i,
  output csr_pkg::word_t     cnt_o,
  output csr_pkg::word_t     cmp_o,
  output logic               irq_o
);
  import csr_pkg::*;

  logic  cnt_sw_hit;
  logic  match;
  word_t cnt_next;

  assign cnt_sw_hit = csr_enable_i && (csr_addr_i == csr_addr_t'(`CLIC_TIMER_CNT_ADDR));

  // compare of zero keeps the timer silent
  assign match    = (cmp_o != '0) && (cnt_o == cmp_o);
  assign cnt_next = match ? '0 : cnt_o + 1'b1;

  // counts in hardware unless software is writing it this cycle
  csr_reg #(
    .WIDTH (32),
    .ADDR  (csr_addr_t'(`CLIC_TIMER_CNT_ADDR))
  ) u_cnt (
    .clk,
    .reset,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .rs1_data_i,
    .rs1_zimm_i,
    .ext_we_i   (!cnt_sw_hit),
    .ext_data_i (cnt_next),
    .data_o     (cnt_o)
  );

  csr_reg #(
    .WIDTH (32),
    .ADDR  (csr_addr_t'(`CLIC_TIMER_CMP_ADDR))
  ) u_cmp (
    .clk,
    .reset,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .rs1_data_i,
    .rs1_zimm_i,
    .ext_we_i   (1'b0),
    .ext_data_i ('0),
    .data_o     (cmp_o)
  );

  // one-cycle pulse, one edge after the match
  always_ff @(posedge clk) begin
    if (reset) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= match;
    end
  end

endmodule

// File: source/csr_pkg.sv
// CSR access types shared by every register block and the controller top level
package csr_pkg;

  // funct3 encodings of the zicsr instructions
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_t;

  typedef logic [11:0] csr_addr_t;

  typedef logic [31:0] word_t;

  // rs1 field used as an unsigned immediate
  typedef logic [4:0] zimm_t;

endpackage

// File: source/csr_reg.sv
// single CSR with zicsr write/set/clear access and a hardware write port that wins
`timescale 1ns/1ps

module csr_reg #(
  parameter int                 WIDTH = 32,
  parameter csr_pkg::csr_addr_t ADDR  = '0
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               csr_enable_i,
  input  csr_pkg::csr_addr_t csr_addr_i,
  input  csr_pkg::csr_op_t   csr_op_i,
  input  csr_pkg::word_t     rs1_data_i,
  input  csr_pkg::zimm_t     rs1_zimm_i,
  input  logic               ext_we_i,
  input  logic [WIDTH-1:0]   ext_data_i,
  output logic [WIDTH-1:0]   data_o
);
  import csr_pkg::*;

  word_t operand;
  word_t current;
  word_t next_val;
  logic  sw_hit;

  assign sw_hit = csr_enable_i && (csr_addr_i == ADDR);

  always_comb begin
    current = word_t'(data_o);
    // immediate forms take the zero-extended rs1 field
    case (csr_op_i)
      CSR_RWI, CSR_RSI, CSR_RCI: operand = word_t'(rs1_zimm_i);
      default:                   operand = rs1_data_i;
    endcase
    case (csr_op_i)
      CSR_RW, CSR_RWI: next_val = operand;
      CSR_RS, CSR_RSI: next_val = current | operand;
      CSR_RC, CSR_RCI: next_val = current & ~operand;
      default:         next_val = current;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_o <= '0;
    end else if (ext_we_i) begin
      data_o <= ext_data_i;
    end else if (sw_hit) begin
      data_o <= next_val[WIDTH-1:0];
    end
  end

endmodule

// File: source/epc_stack.sv
// return stack for nested interrupts, holds saved pc, id and threshold per level
`timescale 1ns/1ps

module epc_stack #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 23
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             push_i,
  input  logic             pop_i,
  input  logic [WIDTH-1:0] data_i,
  output logic [WIDTH-1:0] data_o,
  output clic_pkg::level_t level_o
);
  import clic_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [IDX_W-1:0] top_idx;
  logic             full;
  logic             empty;

  assign full    = (level_o == level_t'(DEPTH));
  assign empty   = (level_o == '0);
  assign top_idx = IDX_W'(level_o - 1'b1);

  // an empty stack reads as zero
  assign data_o = empty ? '0 : mem[top_idx];

  // entries themselves need no clearing
  always_ff @(posedge clk) begin
    if (push_i && !full) begin
      mem[level_o[IDX_W-1:0]] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      level_o <= '0;
    end else if (push_i && !full) begin
      level_o <= level_o + 1'b1;
    end else if (pop_i && !empty) begin
      level_o <= level_o - 1'b1;
    end
  end

endmodule

// File: source/n_clic.sv
// vectored interrupt controller top, the core drives CSR accesses and its pc into it
`timescale 1ns/1ps
`include "clic_cfg.svh"

module n_clic (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 csr_enable_i,
  input  csr_pkg::csr_addr_t   csr_addr_i,
  input  csr_pkg::csr_op_t     csr_op_i,
  input  csr_pkg::word_t       rs1_data_i,
  input  csr_pkg::zimm_t       rs1_zimm_i,
  input  clic_pkg::imem_addr_t pc_i,
  input  logic                 interrupt_in_i,
  output csr_pkg::word_t       csr_out_o,
  output clic_pkg::imem_addr_t int_addr_o,
  output clic_pkg::vec_id_t    int_id_o,
  output clic_pkg::prio_t      int_prio_o,
  output clic_pkg::pc_sel_t    pc_interrupt_sel_o,
  output clic_pkg::level_t     level_o,
  output logic                 interrupt_o,
  output logic                 tail_chain_o
);
  import csr_pkg::*;
  import clic_pkg::*;

  localparam int VEC_SIZE  = `CLIC_VEC_SIZE;
  localparam int PRIO_W    = `CLIC_PRIO_WIDTH;
  localparam int VEC_W     = `CLIC_IMEM_ADDR_WIDTH - 2;
  localparam int ENTRY_W   = PRIO_W + 2;
  localparam int IDX_W     = $clog2(VEC_SIZE);
  localparam int STACK_W   = $bits(imem_addr_t) + $bits(vec_id_t) + $bits(prio_t);
  localparam int MSTATUS_W = 4;
  localparam int MIE_BIT   = 3;
  localparam int PEND_BIT  = 0;
  localparam int EN_BIT    = 1;

  logic [MSTATUS_W-1:0] mstatus_q;
  prio_t                thresh_q;
  logic                 thresh_we;
  prio_t                thresh_data;
  logic [VEC_W-1:0]     vec_q        [VEC_SIZE];
  logic [ENTRY_W-1:0]   entry_q      [VEC_SIZE];
  logic                 entry_we     [VEC_SIZE-1];
  logic [ENTRY_W-1:0]   entry_data   [VEC_SIZE-1];

  word_t                timer_cnt;
  word_t                timer_cmp;
  logic                 timer_irq;

  logic                 push;
  logic                 pop;
  logic [STACK_W-1:0]   stack_top;
  imem_addr_t           saved_addr;
  vec_id_t              saved_id;
  prio_t                saved_prio;
  vec_id_t              cur_id;

  prio_t                best_prio;
  logic [IDX_W-1:0]     best_idx;
  logic                 best_hit;
  logic                 pc_is_ret;
  clic_action_t         action;

  csr_reg #(
    .WIDTH (MSTATUS_W),
    .ADDR  (csr_addr_t'(`CLIC_MSTATUS_ADDR))
  ) u_mstatus (
    .clk,
    .reset,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .rs1_data_i,
    .rs1_zimm_i,
    .ext_we_i   (1'b0),
    .ext_data_i ('0),
    .data_o     (mstatus_q)
  );

  csr_reg #(
    .WIDTH (PRIO_W),
    .ADDR  (csr_addr_t'(`CLIC_THRESH_ADDR))
  ) u_thresh (
    .clk,
    .reset,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .rs1_data_i,
    .rs1_zimm_i,
    .ext_we_i   (thresh_we),
    .ext_data_i (thresh_data),
    .data_o     (thresh_q)
  );

  // handler word addresses, one per source
  for (genvar k = 0; k < VEC_SIZE; k++) begin : gen_vec
    csr_reg #(
      .WIDTH (VEC_W),
      .ADDR  (csr_addr_t'(`CLIC_VEC_BASE + k))
    ) u_vec (
      .clk,
      .reset,
      .csr_enable_i,
      .csr_addr_i,
      .csr_op_i,
      .rs1_data_i,
      .rs1_zimm_i,
      .ext_we_i   (1'b0),
      .ext_data_i ('0),
      .data_o     (vec_q[k])
    );
  end

  // entry layout from lsb is pending, enable, priority
  for (genvar k = 0; k < VEC_SIZE - 1; k++) begin : gen_entry
    csr_reg #(
      .WIDTH (ENTRY_W),
      .ADDR  (csr_addr_t'(`CLIC_ENTRY_BASE + k))
    ) u_entry (
      .clk,
      .reset,
      .csr_enable_i,
      .csr_addr_i,
      .csr_op_i,
      .rs1_data_i,
      .rs1_zimm_i,
      .ext_we_i   (entry_we[k]),
      .ext_data_i (entry_data[k]),
      .data_o     (entry_q[k])
    );
  end

  // fault line, top priority and always enabled
  assign entry_q[VEC_SIZE-1] = {{PRIO_W{1'b1}}, 1'b1, interrupt_in_i};

  clic_timer u_timer (
    .clk,
    .reset,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .rs1_data_i,
    .rs1_zimm_i,
    .cnt_o (timer_cnt),
    .cmp_o (timer_cmp),
    .irq_o (timer_irq)
  );

  epc_stack #(
    .DEPTH (`CLIC_STACK_DEPTH),
    .WIDTH (STACK_W)
  ) u_stack (
    .clk,
    .reset,
    .push_i  (push),
    .pop_i   (pop),
    .data_i  ({pc_i, cur_id, thresh_q}),
    .data_o  (stack_top),
    .level_o (level_o)
  );

  assign {saved_addr, saved_id, saved_prio} = stack_top;
  assign pc_is_ret = (pc_i == '1);

  // running max from the threshold, >= lets a higher index win a tie
  always_comb begin
    best_prio = thresh_q;
    best_idx  = '0;
    best_hit  = 1'b0;
    for (int k = 0; k < VEC_SIZE; k++) begin
      if (entry_q[k][EN_BIT] && entry_q[k][PEND_BIT] &&
          (entry_q[k][ENTRY_W-1:2] >= best_prio)) begin
        best_prio = entry_q[k][ENTRY_W-1:2];
        best_idx  = IDX_W'(k);
        best_hit  = 1'b1;
      end
    end
  end

  always_comb begin
    action = ACT_NONE;
    if (mstatus_q[MIE_BIT]) begin
      if (best_hit && (best_prio > thresh_q)) begin
        action = ACT_TAKE;
      end else if (pc_is_ret && best_hit) begin
        action = ACT_TAIL;
      end else if (pc_is_ret) begin
        action = ACT_RETURN;
      end
    end
  end

  always_comb begin
    push               = 1'b0;
    pop                = 1'b0;
    thresh_we          = 1'b0;
    thresh_data        = thresh_q;
    int_addr_o         = pc_i;
    int_id_o           = cur_id;
    int_prio_o         = thresh_q;
    interrupt_o        = 1'b0;
    tail_chain_o       = 1'b0;
    pc_interrupt_sel_o = PC_NORMAL;
    case (action)
      ACT_TAKE, ACT_TAIL: begin
        push               = (action == ACT_TAKE);
        thresh_we          = 1'b1;
        thresh_data        = best_prio;
        // vector holds a word address
        int_addr_o         = {vec_q[best_idx], 2'b00};
        int_id_o           = vec_id_t'(best_idx);
        int_prio_o         = best_prio;
        interrupt_o        = 1'b1;
        tail_chain_o       = (action == ACT_TAIL);
        pc_interrupt_sel_o = PC_INTERRUPT;
      end
      ACT_RETURN: begin
        pop                = 1'b1;
        thresh_we          = 1'b1;
        thresh_data        = saved_prio;
        int_addr_o         = saved_addr;
        int_id_o           = saved_id;
        int_prio_o         = saved_prio;
        pc_interrupt_sel_o = PC_INTERRUPT;
      end
      default: begin
      end
    endcase
  end

  // taken entry drops its pending bit, a timer pulse in the same cycle still pends 0
  always_comb begin
    for (int k = 0; k < VEC_SIZE - 1; k++) begin
      entry_we[k]   = 1'b0;
      entry_data[k] = entry_q[k];
    end
    if ((action == ACT_TAKE || action == ACT_TAIL) && (best_idx != IDX_W'(VEC_SIZE - 1))) begin
      entry_we[best_idx]             = 1'b1;
      entry_data[best_idx][PEND_BIT] = 1'b0;
    end
    if (timer_irq) begin
      entry_we[0]             = 1'b1;
      entry_data[0][PEND_BIT] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cur_id <= '0;
    end else if (action == ACT_TAKE || action == ACT_TAIL) begin
      cur_id <= vec_id_t'(best_idx);
    end else if (action == ACT_RETURN) begin
      cur_id <= saved_id;
    end
  end

  // read mux, shows register contents before any write this cycle
  always_comb begin
    csr_out_o = '0;
    if (csr_addr_i == csr_addr_t'(`CLIC_MSTATUS_ADDR)) begin
      csr_out_o = word_t'(mstatus_q);
    end else if (csr_addr_i == csr_addr_t'(`CLIC_THRESH_ADDR)) begin
      csr_out_o = word_t'(thresh_q);
    end else if (csr_addr_i == csr_addr_t'(`CLIC_DEPTH_ADDR)) begin
      csr_out_o = word_t'(level_o);
    end else if (csr_addr_i == csr_addr_t'(`CLIC_TIMER_CNT_ADDR)) begin
      csr_out_o = timer_cnt;
    end else if (csr_addr_i == csr_addr_t'(`CLIC_TIMER_CMP_ADDR)) begin
      csr_out_o = timer_cmp;
    end else begin
      for (int k = 0; k < VEC_SIZE; k++) begin
        if (csr_addr_i == csr_addr_t'(`CLIC_VEC_BASE + k)) begin
          csr_out_o = word_t'(vec_q[k]);
        end
        if (csr_addr_i == csr_addr_t'(`CLIC_ENTRY_BASE + k)) begin
          csr_out_o = word_t'(entry_q[k]);
        end
      end
    end
  end

endmodule
